/* Bender.yml */
package:
  name: dispatch_unit

sources:
  - source/dispatch_pkg.sv
  - source/inst_decoder.sv
  - source/register_file.sv
  - source/register_status_table.sv
  - source/tag_fifo.sv
  - source/dispatch_control.sv
  - source/dispatch_unit.sv
  - target: test
    files:
      - sim/clock_gen.sv
      - sim/dispatch_tb.sv

/* all.f */
source/dispatch_pkg.sv
source/inst_decoder.sv
source/register_file.sv
source/register_status_table.sv
source/tag_fifo.sv
source/dispatch_control.sv
source/dispatch_unit.sv
sim/clock_gen.sv
sim/dispatch_tb.sv

/* sim/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // Half of the 40 ns period
   always begin
      #20;
      clk = ~clk;
   end

endmodule

/* sim/dispatch_tb.sv */
`timescale 1ns/1ns

module dispatch_tb import dispatch_pkg::*; ();

   typedef struct packed {
      logic [3:0] en;
      opcode_t    int_opcode;
      logic       ls_opcode;
      logic       needs_tag;
      logic       is_load;
      reg_addr_t  dest;
      tag_t       rd_tag;
      tag_t       rs_tag;
      tag_t       rt_tag;
      word_t      rs_data;
      word_t      rt_data;
      logic       rs_valid;
      logic       rt_valid;
   } expect_t;

   logic      clk;
   logic      rst;
   word_t     ifq_inst;
   word_t     ifq_pc_plus4;
   logic      ifq_empty;
   logic      ifq_ren;
   logic      ifq_branch_valid;
   word_t     ifq_branch_addr;
   logic      cdb_valid;
   tag_t      cdb_tag;
   word_t     cdb_data;
   logic      cdb_branch;
   logic      cdb_branch_taken;
   imm_t      queue_imm;
   tag_t      queue_rd_tag;
   tag_t      queue_rs_tag;
   tag_t      queue_rt_tag;
   word_t     queue_rs_data;
   word_t     queue_rt_data;
   logic      queue_rs_valid;
   logic      queue_rt_valid;
   logic      int_en;
   opcode_t   int_opcode;
   logic      int_ready;
   logic      ls_en;
   logic      ls_opcode;
   logic      ls_ready;
   logic      mult_en;
   logic      mult_ready;
   logic      div_en;
   logic      div_ready;
   reg_addr_t debug_addr;
   word_t     debug_data;

   // Reference state of the tag FIFO, the status table and the register file
   tag_t        free_tags [$];
   tag_t        outstanding [$];
   logic        busy_m [num_regs];
   tag_t        tag_m [num_regs];
   word_t       reg_m [num_regs];
   tag_t        last_rd_tag;
   logic [31:0] rng;
   string       test_name;
   int          test_errors;
   int          total_errors;
   int          tests_run;
   int          tests_failed;

   clock_gen clock_gen_inst (.clk);

   dispatch_unit dispatch_unit_inst (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   function automatic word_t r_type(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd, opcode_t funct);
      return {opcode_rtype, rs, rt, rd, 5'd0, funct};
   endfunction

   function automatic word_t i_type(opcode_t op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
      return {op, rs, rt, imm};
   endfunction

   // Expected dispatch of one instruction, given this cycle's CDB inputs
   function automatic expect_t predict(word_t inst, logic cv, tag_t ct, word_t cd);
      expect_t   e;
      opcode_t   op;
      opcode_t   funct;
      reg_addr_t rs;
      reg_addr_t rt;
      logic      rs_fwd;
      logic      rt_fwd;
      op = inst[31:26];
      rs = inst[25:21];
      rt = inst[20:16];
      funct = inst[5:0];
      e = '0;
      e.dest = inst[15:11];
      if (free_tags.size() > 0) begin
         e.rd_tag = free_tags[0];
      end
      case (op)
         opcode_rtype: begin
            e.needs_tag = 1'b1;
            if (funct == funct_mult || funct == funct_multu) begin
               e.en = 4'b0010;
            end else if (funct == funct_div || funct == funct_divu) begin
               e.en = 4'b0001;
            end else begin
               e.en = 4'b1000;
               e.int_opcode = funct;
            end
         end
         opcode_beq, opcode_bne: begin
            e.en = 4'b1000;
            e.int_opcode = op;
         end
         opcode_lw: begin
            e.en = 4'b0100;
            e.needs_tag = 1'b1;
            e.is_load = 1'b1;
            e.dest = rt;
            e.ls_opcode = ls_func_lw;
         end
         opcode_sw: begin
            e.en = 4'b0100;
            e.ls_opcode = ls_func_sw;
         end
         default: e.en = 4'b0000;
      endcase
      // A result on the CDB in this cycle counts as already written
      rs_fwd = busy_m[rs] && cv && (tag_m[rs] == ct);
      rt_fwd = busy_m[rt] && cv && (tag_m[rt] == ct);
      e.rs_tag = tag_m[rs];
      e.rs_valid = !busy_m[rs] || rs_fwd;
      e.rs_data = rs_fwd ? cd : reg_m[rs];
      if (e.is_load) begin
         e.rt_tag = e.rd_tag;
         e.rt_valid = 1'b1;
      end else begin
         e.rt_tag = tag_m[rt];
         e.rt_valid = !busy_m[rt] || rt_fwd;
         e.rt_data = rt_fwd ? cd : reg_m[rt];
      end
      return e;
   endfunction

   task automatic report_mismatch(string what, logic [31:0] expected, logic [31:0] actual);
      $display("CHECK FAILED %s %s: expected %0h actual %0h", test_name, what, expected, actual);
      test_errors++;
   endtask

   task automatic report_problem(string what);
      $display("ERROR %s: %s", test_name, what);
      test_errors++;
   endtask

   task automatic start_test(string name);
      test_name = name;
      test_errors = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors == 0) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, test_errors);
      end
   endtask

   // Compares every enable cycle with the reference and then advances the model
   always @(posedge clk) begin : compare
      expect_t    e;
      logic [3:0] en_seen;
      logic       do_set;
      do_set = 1'b0;
      if (!rst) begin
         en_seen = {int_en, ls_en, mult_en, div_en};
         if (en_seen != 4'b0000) begin
            e = predict(ifq_inst, cdb_valid, cdb_tag, cdb_data);
            assert (en_seen == e.en) else report_mismatch("enables", e.en, en_seen);
            assert (ifq_ren) else report_problem("queue enable without a fetch read");
            assert (queue_imm == ifq_inst[15:0]) else
               report_mismatch("immediate", ifq_inst[15:0], queue_imm);
            if (e.en[3]) begin
               assert (int_opcode == e.int_opcode) else
                  report_mismatch("int opcode", e.int_opcode, int_opcode);
            end
            if (e.en[2]) begin
               assert (ls_opcode == e.ls_opcode) else
                  report_mismatch("ls opcode", e.ls_opcode, ls_opcode);
            end
            if (e.needs_tag) begin
               assert (queue_rd_tag == e.rd_tag) else
                  report_mismatch("rd tag", e.rd_tag, queue_rd_tag);
            end
            assert (queue_rs_valid == e.rs_valid) else
               report_mismatch("rs valid", e.rs_valid, queue_rs_valid);
            if (e.rs_valid) begin
               assert (queue_rs_data == e.rs_data) else
                  report_mismatch("rs data", e.rs_data, queue_rs_data);
            end else begin
               assert (queue_rs_tag == e.rs_tag) else
                  report_mismatch("rs tag", e.rs_tag, queue_rs_tag);
            end
            assert (queue_rt_valid == e.rt_valid) else
               report_mismatch("rt valid", e.rt_valid, queue_rt_valid);
            if (e.is_load || !e.rt_valid) begin
               assert (queue_rt_tag == e.rt_tag) else
                  report_mismatch("rt tag", e.rt_tag, queue_rt_tag);
            end else begin
               assert (queue_rt_data == e.rt_data) else
                  report_mismatch("rt data", e.rt_data, queue_rt_data);
            end
            if (e.needs_tag && free_tags.size() > 0) begin
               void'(free_tags.pop_front());
               outstanding.push_back(e.rd_tag);
               // The tag that the DUT actually issued
               last_rd_tag = queue_rd_tag;
               do_set = 1'b1;
            end
         end
         if (cdb_valid) begin
            for (int i = 0; i < num_regs; i++) begin
               if (busy_m[i] && tag_m[i] == cdb_tag) begin
                  busy_m[i] = 1'b0;
                  reg_m[i] = cdb_data;
               end
            end
            free_tags.push_back(cdb_tag);
            for (int k = 0; k < outstanding.size(); k++) begin
               if (outstanding[k] == cdb_tag) begin
                  outstanding.delete(k);
                  break;
               end
            end
         end
         // The new producer wins over a clear of the same register
         if (do_set) begin
            busy_m[e.dest] = 1'b1;
            tag_m[e.dest] = e.rd_tag;
         end
      end
   end

   task automatic set_ready(queue_e q, logic v);
      case (q)
         queue_int:  int_ready = v;
         queue_ls:   ls_ready = v;
         queue_mult: mult_ready = v;
         default:    div_ready = v;
      endcase
   endtask

   task automatic wait_for_ren(string what);
      int n;
      n = 0;
      @(posedge clk);
      while (!ifq_ren && n < 100) begin
         n++;
         @(posedge clk);
      end
      if (!ifq_ren) begin
         report_problem($sformatf("timed out waiting for the fetch read of %s", what));
      end
   endtask

   // Stimulus tasks start and end at a falling edge
   task automatic send(word_t inst, word_t pc4, string what);
      ifq_inst = inst;
      ifq_pc_plus4 = pc4;
      ifq_empty = 1'b0;
      wait_for_ren(what);
      @(negedge clk);
      ifq_empty = 1'b1;
   endtask

   task automatic broadcast(tag_t tag, word_t data);
      cdb_valid = 1'b1;
      cdb_tag = tag;
      cdb_data = data;
      @(negedge clk);
      cdb_valid = 1'b0;
   endtask

   task automatic expect_hold(int cycles, string what);
      repeat (cycles) begin
         @(posedge clk);
         assert (!ifq_ren && {int_en, ls_en, mult_en, div_en} == 4'b0000) else
            report_problem($sformatf("%s was consumed while it should be held", what));
      end
      @(negedge clk);
   endtask

   task automatic send_held(word_t inst, queue_e q, string what);
      int span;
      span = 2 + int'(next_rand() % 6);
      set_ready(q, 1'b0);
      ifq_inst = inst;
      ifq_empty = 1'b0;
      expect_hold(span, what);
      set_ready(q, 1'b1);
      wait_for_ren(what);
      @(negedge clk);
      ifq_empty = 1'b1;
   endtask

   initial begin
      word_t     data;
      word_t     target;
      reg_addr_t ra;
      reg_addr_t rb;
      reg_addr_t rc;
      tag_t      t;
      imm_t      bimm;
      rst = 1'b1;
      ifq_inst = '0;
      ifq_pc_plus4 = '0;
      ifq_empty = 1'b1;
      cdb_valid = 1'b0;
      cdb_tag = '0;
      cdb_data = '0;
      cdb_branch = 1'b0;
      cdb_branch_taken = 1'b0;
      int_ready = 1'b1;
      ls_ready = 1'b1;
      mult_ready = 1'b1;
      div_ready = 1'b1;
      debug_addr = '0;
      rng = 32'd14;
      last_rd_tag = '0;
      test_errors = 0;
      total_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      for (int i = 0; i < num_tags; i++) begin
         free_tags.push_back(tag_t'(i));
      end
      for (int i = 0; i < num_regs; i++) begin
         busy_m[i] = 1'b0;
         tag_m[i] = '0;
         reg_m[i] = '0;
      end
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      start_test("routing");
      send(r_type(5'd1, 5'd2, 5'd3, 6'h20), 32'h0000_0104, "ADD");
      send(r_type(5'd4, 5'd5, 5'd6, funct_mult), 32'h0000_0108, "MULT");
      send(r_type(5'd7, 5'd8, 5'd9, funct_div), 32'h0000_010c, "DIV");
      send(i_type(opcode_lw, 5'd10, 5'd11, 16'h0010), 32'h0000_0110, "LW");
      send(i_type(opcode_sw, 5'd12, 5'd13, 16'h0020), 32'h0000_0114, "SW");
      assert (last_rd_tag == 6'd3) else report_mismatch("last tag", 6'd3, last_rd_tag);
      finish_test();

      start_test("dependencies");
      data = next_rand();
      ra = data[4:0];
      rb = ra + 5'd1;
      rc = ra + 5'd2;
      send(r_type(rb, rb, ra, 6'h21), 32'h0000_0200, "producer");
      t = last_rd_tag;
      send(r_type(ra, ra, rc, 6'h20), 32'h0000_0204, "waiting reader");
      data = next_rand();
      broadcast(t, data);
      send(r_type(ra, ra, rc, 6'h20), 32'h0000_0208, "ready reader");
      debug_addr = ra;
      @(posedge clk);
      assert (debug_data == data) else report_mismatch("debug data", data, debug_data);
      @(negedge clk);
      send(r_type(ra, ra, rb, 6'h20), 32'h0000_020c, "second producer");
      t = last_rd_tag;
      data = next_rand();
      ifq_inst = r_type(rb, rb, rc, 6'h22);
      ifq_empty = 1'b0;
      cdb_valid = 1'b1;
      cdb_tag = t;
      cdb_data = data;
      @(posedge clk);
      assert (ifq_ren) else report_problem("reader did not dispatch alongside the broadcast");
      assert (queue_rs_valid && queue_rs_data == data) else
         report_mismatch("forwarded rs", data, queue_rs_data);
      @(negedge clk);
      ifq_empty = 1'b1;
      cdb_valid = 1'b0;
      finish_test();

      start_test("back-pressure");
      send_held(r_type(5'd14, 5'd15, 5'd16, funct_multu), queue_mult, "MULTU");
      send_held(r_type(5'd17, 5'd18, 5'd19, 6'h24), queue_int, "AND");
      send_held(i_type(opcode_lw, 5'd20, 5'd21, 16'h0040), queue_ls, "LW");
      send_held(r_type(5'd22, 5'd23, 5'd24, funct_divu), queue_div, "DIVU");
      finish_test();

      start_test("jump");
      data = next_rand();
      ifq_inst = {opcode_j, data[25:0]};
      ifq_pc_plus4 = 32'ha000_0104;
      ifq_empty = 1'b0;
      target = {ifq_pc_plus4[31:28], data[25:0], 2'b00};
      wait_for_ren("J");
      assert (ifq_branch_valid) else report_problem("jump did not redirect fetch");
      assert (ifq_branch_addr == target) else
         report_mismatch("jump address", target, ifq_branch_addr);
      @(negedge clk);
      ifq_empty = 1'b1;
      @(posedge clk);
      assert (!ifq_branch_valid) else report_problem("jump redirect lasted more than a cycle");
      @(negedge clk);
      finish_test();

      start_test("branches");
      send(i_type(opcode_beq, 5'd1, 5'd2, 16'h0008), 32'h0000_0300, "BEQ");
      ifq_inst = r_type(5'd3, 5'd4, 5'd5, 6'h20);
      ifq_empty = 1'b0;
      expect_hold(4, "ADD behind BEQ");
      cdb_branch = 1'b1;
      cdb_branch_taken = 1'b0;
      @(posedge clk);
      assert (ifq_ren && int_en) else report_problem("not-taken outcome did not release the ADD");
      assert (!ifq_branch_valid) else report_problem("not-taken outcome redirected fetch");
      @(negedge clk);
      cdb_branch = 1'b0;
      ifq_empty = 1'b1;
      // A negative displacement checks the sign extension
      bimm = 16'hfff0;
      target = 32'h0000_0400 + ({{16{bimm[15]}}, bimm} << 2);
      send(i_type(opcode_bne, 5'd6, 5'd7, bimm), 32'h0000_0400, "BNE");
      ifq_inst = r_type(5'd8, 5'd9, 5'd10, 6'h20);
      ifq_empty = 1'b0;
      expect_hold(3, "ADD behind BNE");
      cdb_branch = 1'b1;
      cdb_branch_taken = 1'b1;
      @(posedge clk);
      assert (ifq_branch_valid) else report_problem("taken outcome did not redirect fetch");
      assert (ifq_branch_addr == target) else
         report_mismatch("branch target", target, ifq_branch_addr);
      assert (!ifq_ren) else report_problem("taken outcome also dispatched");
      @(negedge clk);
      cdb_branch = 1'b0;
      cdb_branch_taken = 1'b0;
      ifq_empty = 1'b1;
      finish_test();

      start_test("tag recycling");
      for (int k = 0; k < num_tags && free_tags.size() > 0; k++) begin
         data = next_rand();
         send(r_type(data[4:0], data[9:5], data[14:10], 6'h20), 32'h0000_0500, "ADD");
      end
      assert (free_tags.size() == 0) else report_problem("tag FIFO never ran empty");
      ifq_inst = r_type(5'd1, 5'd2, 5'd3, 6'h20);
      ifq_empty = 1'b0;
      expect_hold(4, "ADD with no free tag");
      t = outstanding[0];
      data = next_rand();
      broadcast(t, data);
      wait_for_ren("ADD after a tag return");
      @(negedge clk);
      ifq_empty = 1'b1;
      assert (last_rd_tag == t) else report_mismatch("reissued tag", t, last_rd_tag);
      finish_test();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
      if (total_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* source/dispatch_control.sv */
`timescale 1ns/1ns

module dispatch_control import dispatch_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  queue_e      queue,
   input  logic        needs_queue,
   input  logic        needs_tag,
   input  logic        is_branch,
   input  logic        is_jump,
   input  logic        is_load,
   input  imm_t        imm,
   input  word_t       branch_target_offset,
   input  logic [25:0] jump_index,
   input  logic        ifq_empty,
   input  word_t       ifq_pc_plus4,
   input  logic        int_ready,
   input  logic        ls_ready,
   input  logic        mult_ready,
   input  logic        div_ready,
   input  logic        tag_empty,
   input  tag_t        head_tag,
   input  tag_t        rs_tag,
   input  tag_t        rt_tag,
   input  logic        rs_busy,
   input  logic        rt_busy,
   input  word_t       rs_data,
   input  word_t       rt_data,
   input  logic        cdb_valid,
   input  tag_t        cdb_tag,
   input  word_t       cdb_data,
   input  logic        cdb_branch,
   input  logic        cdb_branch_taken,
   output logic        int_en,
   output logic        ls_en,
   output logic        mult_en,
   output logic        div_en,
   output logic        ifq_ren,
   output logic        ifq_branch_valid,
   output word_t       ifq_branch_addr,
   output logic        tag_pop,
   output logic        status_set,
   output imm_t        queue_imm,
   output tag_t        queue_rd_tag,
   output tag_t        queue_rs_tag,
   output tag_t        queue_rt_tag,
   output word_t       queue_rs_data,
   output word_t       queue_rt_data,
   output logic        queue_rs_valid,
   output logic        queue_rt_valid
);

   dispatch_state_e state;
   dispatch_state_e next_state;
   word_t           branch_target_r;
   logic            state_ok;
   logic            queue_ready;
   logic            can_dispatch;
   logic            jump_fire;
   logic            taken_redirect;
   logic            rs_fwd;
   logic            rt_fwd;

   // While stalled, only a not-taken outcome in this same cycle lets the next instruction go
   assign state_ok = (state == st_dispatch) || (cdb_branch && !cdb_branch_taken);

   always_comb begin
      case (queue)
         queue_int:  queue_ready = int_ready;
         queue_ls:   queue_ready = ls_ready;
         queue_mult: queue_ready = mult_ready;
         default:    queue_ready = div_ready;
      endcase
   end

   assign can_dispatch = !ifq_empty && needs_queue && queue_ready && state_ok
                         && (!needs_tag || !tag_empty);
   assign jump_fire      = !ifq_empty && is_jump && state_ok;
   assign taken_redirect = (state == st_branch_stall) && cdb_branch && cdb_branch_taken;

   assign int_en     = can_dispatch && (queue == queue_int);
   assign ls_en      = can_dispatch && (queue == queue_ls);
   assign mult_en    = can_dispatch && (queue == queue_mult);
   assign div_en     = can_dispatch && (queue == queue_div);
   assign ifq_ren    = can_dispatch || jump_fire;
   assign tag_pop    = can_dispatch && needs_tag;
   assign status_set = tag_pop;

   assign ifq_branch_valid = jump_fire || taken_redirect;
   assign ifq_branch_addr  = jump_fire ? {ifq_pc_plus4[31:28], jump_index, 2'b00}
                                       : branch_target_r;

   // A result broadcast in the dispatch cycle has not reached the register file yet
   assign rs_fwd = rs_busy && cdb_valid && (cdb_tag == rs_tag);
   assign rt_fwd = rt_busy && cdb_valid && (cdb_tag == rt_tag);

   assign queue_imm      = imm;
   assign queue_rd_tag   = head_tag;
   assign queue_rs_tag   = rs_tag;
   assign queue_rs_data  = rs_fwd ? cdb_data : rs_data;
   assign queue_rs_valid = !rs_busy || rs_fwd;

   // A load writes rt rather than reading it, so that slot carries its own tag
   assign queue_rt_tag   = is_load ? head_tag : rt_tag;
   assign queue_rt_data  = rt_fwd ? cdb_data : rt_data;
   assign queue_rt_valid = is_load || !rt_busy || rt_fwd;

   always_comb begin
      next_state = state;
      if (can_dispatch && is_branch) begin
         next_state = st_branch_stall;
      end else if (state == st_branch_stall && cdb_branch) begin
         next_state = st_dispatch;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_dispatch;
      end else begin
         state <= next_state;
      end
   end

   // Held until the CDB reports the outcome
   always_ff @(posedge clk) begin
      if (can_dispatch && is_branch) begin
         branch_target_r <= ifq_pc_plus4 + branch_target_offset;
      end
   end

   // The decoder never marks a word both as a queue instruction and as a jump
   one_enable: assert property (@(posedge clk) disable iff (rst)
      $onehot0({int_en, ls_en, mult_en, div_en, jump_fire}));

endmodule

/* source/dispatch_pkg.sv */
package dispatch_pkg;

   localparam int word_bits     = 32;
   localparam int reg_addr_bits = 5;
   localparam int tag_bits      = 6;
   localparam int imm_bits      = 16;
   localparam int opcode_bits   = 6;

   localparam int num_regs = 32;
   localparam int num_tags = 64;

   typedef logic [word_bits-1:0]     word_t;
   typedef logic [reg_addr_bits-1:0] reg_addr_t;
   typedef logic [tag_bits-1:0]      tag_t;
   typedef logic [imm_bits-1:0]      imm_t;
   typedef logic [opcode_bits-1:0]   opcode_t;

   // MIPS primary opcodes that dispatch understands
   localparam opcode_t opcode_rtype = 6'h00;
   localparam opcode_t opcode_j     = 6'h02;
   localparam opcode_t opcode_beq   = 6'h04;
   localparam opcode_t opcode_bne   = 6'h05;
   localparam opcode_t opcode_lw    = 6'h23;
   localparam opcode_t opcode_sw    = 6'h2b;

   // R-type function codes that leave the integer queue
   localparam opcode_t funct_mult  = 6'h18;
   localparam opcode_t funct_multu = 6'h19;
   localparam opcode_t funct_div   = 6'h1a;
   localparam opcode_t funct_divu  = 6'h1b;

   // Opcode seen by the load/store issue queue
   localparam logic ls_func_lw = 1'b0;
   localparam logic ls_func_sw = 1'b1;

   typedef enum logic [1:0] {
      queue_int,
      queue_ls,
      queue_mult,
      queue_div
   } queue_e;

   typedef enum logic {
      st_dispatch,
      st_branch_stall
   } dispatch_state_e;

endpackage

/* source/dispatch_unit.sv */
`timescale 1ns/1ns

module dispatch_unit import dispatch_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  word_t     ifq_inst,
   input  word_t     ifq_pc_plus4,
   input  logic      ifq_empty,
   output logic      ifq_ren,
   output logic      ifq_branch_valid,
   output word_t     ifq_branch_addr,
   input  logic      cdb_valid,
   input  tag_t      cdb_tag,
   input  word_t     cdb_data,
   input  logic      cdb_branch,
   input  logic      cdb_branch_taken,
   output imm_t      queue_imm,
   output tag_t      queue_rd_tag,
   output tag_t      queue_rs_tag,
   output tag_t      queue_rt_tag,
   output word_t     queue_rs_data,
   output word_t     queue_rt_data,
   output logic      queue_rs_valid,
   output logic      queue_rt_valid,
   output logic      int_en,
   output opcode_t   int_opcode,
   input  logic      int_ready,
   output logic      ls_en,
   output logic      ls_opcode,
   input  logic      ls_ready,
   output logic      mult_en,
   input  logic      mult_ready,
   output logic      div_en,
   input  logic      div_ready,
   input  reg_addr_t debug_addr,
   output word_t     debug_data
);

   queue_e              queue;
   logic                needs_queue;
   logic                needs_tag;
   logic                is_branch;
   logic                is_jump;
   logic                is_load;
   reg_addr_t           dest_addr;
   reg_addr_t           rs_addr;
   reg_addr_t           rt_addr;
   imm_t                imm;
   word_t               branch_target_offset;
   logic [25:0]         jump_index;
   logic                tag_empty;
   tag_t                head_tag;
   logic                tag_pop;
   logic                status_set;
   tag_t                rs_tag;
   tag_t                rt_tag;
   logic                rs_busy;
   logic                rt_busy;
   logic [num_regs-1:0] write_onehot;
   word_t               rs_data;
   word_t               rt_data;

   inst_decoder inst_decoder_inst (
      .inst (ifq_inst),
      .queue,
      .needs_queue,
      .needs_tag,
      .is_branch,
      .is_jump,
      .is_load,
      .dest_addr,
      .rs_addr,
      .rt_addr,
      .int_opcode,
      .ls_opcode,
      .imm,
      .branch_target_offset,
      .jump_index
   );

   dispatch_control dispatch_control_inst (
      .clk,
      .rst,
      .queue,
      .needs_queue,
      .needs_tag,
      .is_branch,
      .is_jump,
      .is_load,
      .imm,
      .branch_target_offset,
      .jump_index,
      .ifq_empty,
      .ifq_pc_plus4,
      .int_ready,
      .ls_ready,
      .mult_ready,
      .div_ready,
      .tag_empty,
      .head_tag,
      .rs_tag,
      .rt_tag,
      .rs_busy,
      .rt_busy,
      .rs_data,
      .rt_data,
      .cdb_valid,
      .cdb_tag,
      .cdb_data,
      .cdb_branch,
      .cdb_branch_taken,
      .int_en,
      .ls_en,
      .mult_en,
      .div_en,
      .ifq_ren,
      .ifq_branch_valid,
      .ifq_branch_addr,
      .tag_pop,
      .status_set,
      .queue_imm,
      .queue_rd_tag,
      .queue_rs_tag,
      .queue_rt_tag,
      .queue_rs_data,
      .queue_rt_data,
      .queue_rs_valid,
      .queue_rt_valid
   );

   register_file register_file_inst (
      .clk,
      .rst,
      .rs_addr,
      .rt_addr,
      .debug_addr,
      .write_onehot,
      .cdb_data,
      .rs_data,
      .rt_data,
      .debug_data
   );

   register_status_table register_status_table_inst (
      .clk,
      .rst,
      .rs_addr,
      .rt_addr,
      .set_valid (status_set),
      .set_addr  (dest_addr),
      .set_tag   (head_tag),
      .cdb_valid,
      .cdb_tag,
      .rs_tag,
      .rt_tag,
      .rs_busy,
      .rt_busy,
      .write_onehot
   );

   tag_fifo tag_fifo_inst (
      .clk,
      .rst,
      .pop      (tag_pop),
      .cdb_valid,
      .cdb_tag,
      .head_tag,
      .empty    (tag_empty)
   );

endmodule

/* source/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder import dispatch_pkg::*; (
   input  word_t       inst,
   output queue_e      queue,
   output logic        needs_queue,
   output logic        needs_tag,
   output logic        is_branch,
   output logic        is_jump,
   output logic        is_load,
   output reg_addr_t   dest_addr,
   output reg_addr_t   rs_addr,
   output reg_addr_t   rt_addr,
   output opcode_t     int_opcode,
   output logic        ls_opcode,
   output imm_t        imm,
   output word_t       branch_target_offset,
   output logic [25:0] jump_index
);

   opcode_t   opcode;
   opcode_t   funct;
   reg_addr_t rd_addr;

   // R, I and J formats share the opcode, rs and rt positions
   assign opcode     = inst[31:26];
   assign rs_addr    = inst[25:21];
   assign rt_addr    = inst[20:16];
   assign rd_addr    = inst[15:11];
   assign funct      = inst[5:0];
   assign imm        = inst[15:0];
   assign jump_index = inst[25:0];

   // Branch displacement counts words, so it is shifted into a byte offset
   assign branch_target_offset = {{14{inst[15]}}, inst[15:0], 2'b00};

   always_comb begin
      queue       = queue_int;
      needs_queue = 1'b0;
      needs_tag   = 1'b0;
      is_branch   = 1'b0;
      is_jump     = 1'b0;
      is_load     = 1'b0;
      dest_addr   = rd_addr;
      int_opcode  = '0;
      ls_opcode   = ls_func_lw;
      case (opcode)
         opcode_rtype: begin
            needs_queue = 1'b1;
            needs_tag   = 1'b1;
            case (funct)
               funct_mult, funct_multu: queue = queue_mult;
               funct_div, funct_divu:   queue = queue_div;
               default:                 int_opcode = funct;
            endcase
         end
         opcode_beq, opcode_bne: begin
            // The integer unit resolves the compare and reports it on the CDB
            needs_queue = 1'b1;
            is_branch   = 1'b1;
            int_opcode  = opcode;
         end
         opcode_j: begin
            is_jump = 1'b1;
         end
         opcode_lw: begin
            queue       = queue_ls;
            needs_queue = 1'b1;
            needs_tag   = 1'b1;
            is_load     = 1'b1;
            dest_addr   = rt_addr;
         end
         opcode_sw: begin
            queue       = queue_ls;
            needs_queue = 1'b1;
            ls_opcode   = ls_func_sw;
         end
         default: ;
      endcase
   end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ns

module register_file import dispatch_pkg::*; (
   input  logic                clk,
   input  logic                rst,
   input  reg_addr_t           rs_addr,
   input  reg_addr_t           rt_addr,
   input  reg_addr_t           debug_addr,
   input  logic [num_regs-1:0] write_onehot,
   input  word_t               cdb_data,
   output word_t               rs_data,
   output word_t               rt_data,
   output word_t               debug_data
);

   word_t regs [num_regs];

   assign rs_data    = regs[rs_addr];
   assign rt_data    = regs[rt_addr];
   assign debug_data = regs[debug_addr];

   // Every register waiting on the broadcast tag takes the CDB value
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 0; i < num_regs; i++) begin
            if (write_onehot[i]) begin
               regs[i] <= cdb_data;
            end
         end
      end
   end

   // The tag FIFO hands each tag out once, so a tag is pending in one register at most
   single_writer: assert property (@(posedge clk) disable iff (rst) $onehot0(write_onehot));

endmodule

/* source/register_status_table.sv */
`timescale 1ns/1ns

module register_status_table import dispatch_pkg::*; (
   input  logic                clk,
   input  logic                rst,
   input  reg_addr_t           rs_addr,
   input  reg_addr_t           rt_addr,
   input  logic                set_valid,
   input  reg_addr_t           set_addr,
   input  tag_t                set_tag,
   input  logic                cdb_valid,
   input  tag_t                cdb_tag,
   output tag_t                rs_tag,
   output tag_t                rt_tag,
   output logic                rs_busy,
   output logic                rt_busy,
   output logic [num_regs-1:0] write_onehot
);

   logic [num_regs-1:0] busy;
   tag_t                tags [num_regs];

   assign rs_tag  = tags[rs_addr];
   assign rt_tag  = tags[rt_addr];
   assign rs_busy = busy[rs_addr];
   assign rt_busy = busy[rt_addr];

   always_comb begin
      for (int i = 0; i < num_regs; i++) begin
         write_onehot[i] = cdb_valid && busy[i] && (tags[i] == cdb_tag);
      end
   end

   // A new producer for a register overrides a CDB clear of its older tag
   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= '0;
         for (int i = 0; i < num_regs; i++) begin
            tags[i] <= '0;
         end
      end else begin
         for (int i = 0; i < num_regs; i++) begin
            if (write_onehot[i]) begin
               busy[i] <= 1'b0;
            end
         end
         if (set_valid) begin
            busy[set_addr] <= 1'b1;
            tags[set_addr] <= set_tag;
         end
      end
   end

   set_tag_known: assert property (@(posedge clk) disable iff (rst)
      set_valid |-> !$isunknown(set_tag));

endmodule

/* source/tag_fifo.sv */
`timescale 1ns/1ns

module tag_fifo import dispatch_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic pop,
   input  logic cdb_valid,
   input  tag_t cdb_tag,
   output tag_t head_tag,
   output logic empty
);

   tag_t              mem [num_tags];
   tag_t              rd_ptr;
   tag_t              wr_ptr;
   logic [tag_bits:0] count;
   logic              push;

   // Every result on the CDB frees its tag
   assign push     = cdb_valid;
   assign empty    = (count == '0);
   assign head_tag = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst) begin
         // Starts full with the tags in ascending order
         for (int i = 0; i < num_tags; i++) begin
            mem[i] <= tag_t'(i);
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= (tag_bits + 1)'(num_tags);
      end else begin
         if (push) begin
            mem[wr_ptr] <= cdb_tag;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

   // A returned tag was issued earlier, so the FIFO cannot be full when it comes back
   no_push_full: assert property (@(posedge clk) disable iff (rst)
      push |-> (count < num_tags));

endmodule
